/* dot_accel_top.sv */
/*
  dot-product accelerator top level
  - register file, engine, arbiter and scratch memory
  - host register port and host memory port as plain signals
*/

`timescale 1ns/1ps

module dot_accel_top #(
  parameter int  MAX_LEN = dot_pkg::MAX_LEN_DEF,
  parameter int  ADDR_W  = mem_pkg::ADDR_W,
  localparam int LEN_W   = $clog2(MAX_LEN + 1)
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              csr_we_i,
  input  logic              csr_re_i,
  input  logic [2:0]        csr_addr_i,
  input  logic [63:0]       csr_wdata_i,
  output logic [63:0]       csr_rdata_o,
  output logic              csr_rvalid_o,
  input  logic              hmem_req_i,
  input  logic              hmem_we_i,
  input  logic [ADDR_W-1:0] hmem_addr_i,
  input  logic [63:0]       hmem_wdata_i,
  output logic              hmem_gnt_o,
  output logic              hmem_rvalid_o,
  output logic [63:0]       hmem_rdata_o,
  output logic              done_o
);

  logic                       start;
  logic [ADDR_W-1:0]          a_ptr;
  logic [ADDR_W-1:0]          b_ptr;
  logic [ADDR_W-1:0]          res_ptr;
  logic [LEN_W-1:0]           len;
  logic                       eng_done;
  logic [mem_pkg::DATA_W-1:0] eng_result;
  logic                       mem_en;
  logic                       mem_we;
  logic [ADDR_W-1:0]          mem_addr;
  logic [mem_pkg::DATA_W-1:0] mem_wdata;
  logic [mem_pkg::DATA_W-1:0] mem_rdata;

  mem_bus_if #(.ADDR_W(ADDR_W)) host_bus ();
  mem_bus_if #(.ADDR_W(ADDR_W)) eng_bus ();

  // host memory port onto its bus
  assign host_bus.req   = hmem_req_i;
  assign host_bus.cmd   = hmem_we_i ? mem_pkg::MEM_WRITE : mem_pkg::MEM_READ;
  assign host_bus.addr  = hmem_addr_i;
  assign host_bus.wdata = hmem_wdata_i;
  assign hmem_gnt_o     = host_bus.gnt;
  assign hmem_rvalid_o  = host_bus.rvalid;
  assign hmem_rdata_o   = host_bus.rdata;

  assign done_o = eng_done;

  dot_csr #(.MAX_LEN(MAX_LEN), .ADDR_W(ADDR_W)) u_csr (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .csr_we_i     (csr_we_i),
    .csr_re_i     (csr_re_i),
    .csr_addr_i   (csr_addr_i),
    .csr_wdata_i  (csr_wdata_i),
    .eng_done_i   (eng_done),
    .eng_result_i (eng_result),
    .csr_rdata_o  (csr_rdata_o),
    .csr_rvalid_o (csr_rvalid_o),
    .start_o      (start),
    .a_ptr_o      (a_ptr),
    .b_ptr_o      (b_ptr),
    .res_ptr_o    (res_ptr),
    .len_o        (len)
  );

  dot_engine #(.MAX_LEN(MAX_LEN), .ADDR_W(ADDR_W)) u_engine (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .start_i   (start),
    .a_ptr_i   (a_ptr),
    .b_ptr_i   (b_ptr),
    .res_ptr_i (res_ptr),
    .len_i     (len),
    .done_o    (eng_done),
    .result_o  (eng_result),
    .bus       (eng_bus.requester)
  );

  mem_arbiter #(.ADDR_W(ADDR_W)) u_arbiter (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .host        (host_bus.arbiter),
    .eng         (eng_bus.arbiter),
    .mem_en_o    (mem_en),
    .mem_we_o    (mem_we),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_rdata_i (mem_rdata)
  );

  scratch_mem #(.ADDR_W(ADDR_W)) u_mem (
    .clk_i   (clk_i),
    .en_i    (mem_en),
    .we_i    (mem_we),
    .addr_i  (mem_addr),
    .wdata_i (mem_wdata),
    .rdata_o (mem_rdata)
  );

endmodule

/* dot_csr.sv */
/*
  host register file of the accelerator
  - pointer, length and result pointer registers
  - start command, busy/done status, captured result
  - registered read port with one-cycle read valid
*/

`timescale 1ns/1ps

module dot_csr #(
  parameter int  MAX_LEN = 8,
  parameter int  ADDR_W  = 8,
  localparam int LEN_W   = $clog2(MAX_LEN + 1)
) (
  input  logic              clk_i,
  input  logic              reset_i,
  input  logic              csr_we_i,
  input  logic              csr_re_i,
  input  logic [2:0]        csr_addr_i,
  input  logic [63:0]       csr_wdata_i,
  input  logic              eng_done_i,
  input  logic [63:0]       eng_result_i,
  output logic [63:0]       csr_rdata_o,
  output logic              csr_rvalid_o,
  output logic              start_o,
  output logic [ADDR_W-1:0] a_ptr_o,
  output logic [ADDR_W-1:0] b_ptr_o,
  output logic [ADDR_W-1:0] res_ptr_o,
  output logic [LEN_W-1:0]  len_o
);

  dot_pkg::csr_addr_e addr;
  logic               busy_r;
  logic               done_r;
  logic [63:0]        result_r;
  logic [63:0]        rd_mux;

  assign addr = dot_pkg::csr_addr_e'(csr_addr_i);

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      a_ptr_o   <= '0;
      b_ptr_o   <= '0;
      res_ptr_o <= '0;
      len_o     <= '0;
      start_o   <= 1'b0;
      busy_r    <= 1'b0;
      done_r    <= 1'b0;
      result_r  <= '0;
    end else begin
      start_o <= 1'b0;
      if (csr_we_i) begin
        case (addr)
          dot_pkg::A_PTR:   a_ptr_o   <= csr_wdata_i[ADDR_W-1:0];
          dot_pkg::B_PTR:   b_ptr_o   <= csr_wdata_i[ADDR_W-1:0];
          dot_pkg::RES_PTR: res_ptr_o <= csr_wdata_i[ADDR_W-1:0];
          dot_pkg::LEN: begin
            // longer vectors are clipped to the buffer depth
            if (csr_wdata_i > 64'(MAX_LEN)) begin
              len_o <= LEN_W'(MAX_LEN);
            end else begin
              len_o <= csr_wdata_i[LEN_W-1:0];
            end
          end
          dot_pkg::START: begin
            if (csr_wdata_i != '0 && !busy_r) begin
              start_o <= 1'b1;
              busy_r  <= 1'b1;
              done_r  <= 1'b0;
            end
          end
          default: ;
        endcase
      end
      if (eng_done_i) begin
        busy_r   <= 1'b0;
        done_r   <= 1'b1;
        result_r <= eng_result_i;
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    case (addr)
      dot_pkg::A_PTR:   rd_mux = 64'(a_ptr_o);
      dot_pkg::B_PTR:   rd_mux = 64'(b_ptr_o);
      dot_pkg::LEN:     rd_mux = 64'(len_o);
      dot_pkg::RES_PTR: rd_mux = 64'(res_ptr_o);
      dot_pkg::RESULT:  rd_mux = result_r;
      dot_pkg::STATUS: begin
        rd_mux[dot_pkg::STATUS_BUSY] = busy_r;
        rd_mux[dot_pkg::STATUS_DONE] = done_r;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      csr_rvalid_o <= 1'b0;
    end else begin
      csr_rvalid_o <= csr_re_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (csr_re_i) begin
      csr_rdata_o <= rd_mux;
    end
  end

  // read data only answers a read request of the previous cycle
  a_rvalid_after_re: assert property (
    @(posedge clk_i) disable iff (reset_i)
    csr_rvalid_o |-> $past(csr_re_i)
  );

endmodule

/* dot_engine.sv */
/*
  dot-product engine
  - FSM: fetch A, fetch B, sum, store result, done pulse
  - vector buffers filled one read at a time
  - multiplier row and adder tree over MAX_LEN elements
*/

`timescale 1ns/1ps

module dot_engine #(
  parameter int  MAX_LEN = 8,
  parameter int  ADDR_W  = 8,
  localparam int LEN_W   = $clog2(MAX_LEN + 1)
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  input  logic                       start_i,
  input  logic [ADDR_W-1:0]          a_ptr_i,
  input  logic [ADDR_W-1:0]          b_ptr_i,
  input  logic [ADDR_W-1:0]          res_ptr_i,
  input  logic [LEN_W-1:0]           len_i,
  output logic                       done_o,
  output logic [mem_pkg::DATA_W-1:0] result_o,
  mem_bus_if.requester               bus
);

  localparam int IDX_W  = $clog2(MAX_LEN);
  localparam int LEVELS = $clog2(MAX_LEN);

  dot_pkg::eng_state_e        state_r;
  logic [LEN_W-1:0]           idx_r;
  logic                       pend_r;
  logic                       accept;
  logic [ADDR_W-1:0]          a_ptr_r;
  logic [ADDR_W-1:0]          b_ptr_r;
  logic [ADDR_W-1:0]          res_ptr_r;
  logic [LEN_W-1:0]           len_r;
  logic [mem_pkg::DATA_W-1:0] result_r;
  logic [mem_pkg::DATA_W-1:0] vec_a [MAX_LEN];
  logic [mem_pkg::DATA_W-1:0] vec_b [MAX_LEN];

  if ((MAX_LEN & (MAX_LEN - 1)) != 0) begin : g_len_check
    $error("dot_engine: MAX_LEN must be a power of two");
  end

  assign accept = (state_r == dot_pkg::IDLE) && start_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= dot_pkg::IDLE;
      idx_r   <= '0;
      pend_r  <= 1'b0;
    end else begin
      case (state_r)
        dot_pkg::IDLE: begin
          if (accept) begin
            idx_r   <= '0;
            pend_r  <= 1'b0;
            state_r <= (len_i == '0) ? dot_pkg::SUM : dot_pkg::LOAD_A;
          end
        end
        dot_pkg::LOAD_A, dot_pkg::LOAD_B: begin
          if (bus.gnt) begin
            pend_r <= 1'b1;
          end
          if (bus.rvalid) begin
            pend_r <= 1'b0;
            if (idx_r + 1'b1 == len_r) begin
              idx_r   <= '0;
              state_r <= (state_r == dot_pkg::LOAD_A) ? dot_pkg::LOAD_B : dot_pkg::SUM;
            end else begin
              idx_r <= idx_r + 1'b1;
            end
          end
        end
        dot_pkg::SUM:    state_r <= dot_pkg::STORE;
        dot_pkg::STORE:  if (bus.gnt) state_r <= dot_pkg::FINISH;
        dot_pkg::FINISH: state_r <= dot_pkg::IDLE;
        default:         state_r <= dot_pkg::IDLE;
      endcase
    end
  end

  // job parameters and vector data
  always_ff @(posedge clk_i) begin
    if (accept) begin
      a_ptr_r   <= a_ptr_i;
      b_ptr_r   <= b_ptr_i;
      res_ptr_r <= res_ptr_i;
      len_r     <= len_i;
      // unused tail elements must multiply to zero
      for (int k = 0; k < MAX_LEN; k++) begin
        vec_a[k] <= '0;
        vec_b[k] <= '0;
      end
    end
    if (bus.rvalid && state_r == dot_pkg::LOAD_A) begin
      vec_a[idx_r[IDX_W-1:0]] <= bus.rdata;
    end
    if (bus.rvalid && state_r == dot_pkg::LOAD_B) begin
      vec_b[idx_r[IDX_W-1:0]] <= bus.rdata;
    end
    if (state_r == dot_pkg::SUM) begin
      result_r <= g_lvl[LEVELS].sum[0];
    end
  end

  // products at level 0, pairwise sums above, all mod 2^64
  for (genvar l = 0; l <= LEVELS; l++) begin : g_lvl
    logic [mem_pkg::DATA_W-1:0] sum [MAX_LEN >> l];
    if (l == 0) begin : g_mul
      for (genvar i = 0; i < MAX_LEN; i++) begin : g_el
        assign sum[i] = vec_a[i] * vec_b[i];
      end
    end else begin : g_add
      for (genvar i = 0; i < (MAX_LEN >> l); i++) begin : g_el
        assign sum[i] = g_lvl[l-1].sum[2*i] + g_lvl[l-1].sum[2*i+1];
      end
    end
  end

  always_comb begin
    bus.req   = 1'b0;
    bus.cmd   = mem_pkg::MEM_READ;
    bus.addr  = '0;
    bus.wdata = '0;
    case (state_r)
      dot_pkg::LOAD_A: begin
        bus.req  = !pend_r;
        bus.addr = a_ptr_r + ADDR_W'(idx_r);
      end
      dot_pkg::LOAD_B: begin
        bus.req  = !pend_r;
        bus.addr = b_ptr_r + ADDR_W'(idx_r);
      end
      dot_pkg::STORE: begin
        bus.req   = 1'b1;
        bus.cmd   = mem_pkg::MEM_WRITE;
        bus.addr  = res_ptr_r;
        bus.wdata = result_r;
      end
      default: ;
    endcase
  end

  assign done_o   = (state_r == dot_pkg::FINISH);
  assign result_o = result_r;

  // a stalled request is held until granted
  a_req_hold: assert property (
    @(posedge clk_i) disable iff (reset_i)
    bus.req && !bus.gnt |=> bus.req && $stable(bus.addr) && $stable(bus.cmd)
                            && $stable(bus.wdata)
  );

endmodule

/* dot_pkg.sv */
/*
  dot-product accelerator definitions
  - host register map
  - engine state encoding
  - vector length limit and status bit positions
*/

package dot_pkg;

  // default buffer depth, must stay a power of two
  localparam int MAX_LEN_DEF = 8;

  localparam int STATUS_BUSY = 0;
  localparam int STATUS_DONE = 1;

  typedef enum logic [2:0] {
    A_PTR   = 3'd0,
    B_PTR   = 3'd1,
    LEN     = 3'd2,
    START   = 3'd3,
    STATUS  = 3'd4,
    RES_PTR = 3'd5,
    RESULT  = 3'd6
  } csr_addr_e;

  typedef enum logic [2:0] {
    IDLE   = 3'd0,
    LOAD_A = 3'd1,
    LOAD_B = 3'd2,
    SUM    = 3'd3,
    STORE  = 3'd4,
    FINISH = 3'd5
  } eng_state_e;

endpackage

/* mem_arbiter.sv */
/*
  fixed-priority arbiter for the scratch memory
  - host first, engine otherwise
  - read owner tracking for rvalid and rdata routing
*/

`timescale 1ns/1ps

module mem_arbiter #(
  parameter int ADDR_W = 8
) (
  input  logic                       clk_i,
  input  logic                       reset_i,
  mem_bus_if.arbiter                 host,
  mem_bus_if.arbiter                 eng,
  output logic                       mem_en_o,
  output logic                       mem_we_o,
  output logic [ADDR_W-1:0]          mem_addr_o,
  output logic [mem_pkg::DATA_W-1:0] mem_wdata_o,
  input  logic [mem_pkg::DATA_W-1:0] mem_rdata_i
);

  logic rd_host_r;
  logic rd_eng_r;

  assign host.gnt = host.req;
  assign eng.gnt  = eng.req && !host.req;

  assign mem_en_o    = host.req || eng.req;
  assign mem_we_o    = host.req ? (host.cmd == mem_pkg::MEM_WRITE)
                                : (eng.cmd == mem_pkg::MEM_WRITE);
  assign mem_addr_o  = host.req ? host.addr : eng.addr;
  assign mem_wdata_o = host.req ? host.wdata : eng.wdata;

  // who owns the read data of the next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rd_host_r <= 1'b0;
      rd_eng_r  <= 1'b0;
    end else begin
      rd_host_r <= host.gnt && (host.cmd == mem_pkg::MEM_READ);
      rd_eng_r  <= eng.gnt && (eng.cmd == mem_pkg::MEM_READ);
    end
  end

  assign host.rvalid = rd_host_r;
  assign host.rdata  = rd_host_r ? mem_rdata_i : '0;
  assign eng.rvalid  = rd_eng_r;
  assign eng.rdata   = rd_eng_r ? mem_rdata_i : '0;

  a_one_grant: assert property (
    @(posedge clk_i) disable iff (reset_i)
    !(host.gnt && eng.gnt)
  );

endmodule

/* mem_bus_if.sv */
/*
  memory bus of one requester
  - request side: req, cmd, addr, wdata
  - response side: gnt, rvalid, rdata
  - requester and arbiter views
*/

`timescale 1ns/1ps

interface mem_bus_if #(
  parameter int ADDR_W = mem_pkg::ADDR_W
);

  logic                       req;
  mem_pkg::mem_cmd_e          cmd;
  logic [ADDR_W-1:0]          addr;
  logic [mem_pkg::DATA_W-1:0] wdata;
  logic                       gnt;
  logic                       rvalid;
  logic [mem_pkg::DATA_W-1:0] rdata;

  modport requester (
    output req, cmd, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport arbiter (
    input  req, cmd, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

/* mem_pkg.sv */
/*
  memory bus definitions
  - word and address widths of the scratch memory
  - memory command encoding shared by requesters and arbiter
*/

package mem_pkg;

  localparam int DATA_W = 64;
  // word address, so 256 words by default
  localparam int ADDR_W = 8;

  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_cmd_e;

endpackage

/* run_sim.sh */
#!/bin/sh
# Build and run the dot-product accelerator testbench with Verilator.
# Exit status is 0 only when the log holds the pass line.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_dot_accel -f vlog.f -o tb_sim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "build failed"
  exit 1
fi

./obj_dir/tb_sim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^All tests passed$" "$SIM_LOG"; then
  exit 0
fi
exit 1

/* scratch_mem.sv */
/*
  scratch memory
  - single port, 2^ADDR_W words
  - write at the edge, registered read data
*/

`timescale 1ns/1ps

module scratch_mem #(
  parameter int ADDR_W = 8
) (
  input  logic                       clk_i,
  input  logic                       en_i,
  input  logic                       we_i,
  input  logic [ADDR_W-1:0]          addr_i,
  input  logic [mem_pkg::DATA_W-1:0] wdata_i,
  output logic [mem_pkg::DATA_W-1:0] rdata_o
);

  logic [mem_pkg::DATA_W-1:0] mem [2**ADDR_W];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[addr_i] <= wdata_i;
      end
      // old contents on a write, unused by the arbiter
      rdata_o <= mem[addr_i];
    end
  end

endmodule

/* tb_checker.sv */
/*
  testbench checker
  - samples DUT outputs on the falling edge
  - read data one cycle after the request, done pulse count
  - one line per check, pass and fail counters
*/

`timescale 1ns/1ps

module tb_checker (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        arm_i,
  input  int          kind_i,
  input  logic [63:0] exp_i,
  input  int          row_i,
  input  logic [63:0] csr_rdata_i,
  input  logic        csr_rvalid_i,
  input  logic [63:0] hmem_rdata_i,
  input  logic        hmem_rvalid_i,
  input  logic        done_i,
  output logic        busy_o,
  output int          pass_cnt_o,
  output int          fail_cnt_o
);

  localparam int CSR_RD    = 1;
  localparam int MEM_RD    = 3;
  localparam int WAIT_DONE = 4;

  logic        busy_q = 1'b0;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          done_cnt = 0;
  int          kind_q;
  logic [63:0] exp_q;
  int          row_q;
  int          age;

  assign busy_o     = busy_q;
  assign pass_cnt_o = pass_cnt;
  assign fail_cnt_o = fail_cnt;

  task automatic report(string sig, logic [63:0] got);
    if (got === exp_q) begin
      pass_cnt++;
      $display("PASS row %0d %s = %h", row_q, sig, got);
    end else begin
      fail_cnt++;
      $display("FAIL row %0d %s = %h, expected %h", row_q, sig, got, exp_q);
    end
  endtask

  task automatic fail_words(string what);
    fail_cnt++;
    $display("row %0d failed: %s", row_q, what);
  endtask

  always @(negedge clk_i) begin
    if (reset_i) begin
      busy_q = 1'b0;
    end else begin
      if (done_i) begin
        done_cnt++;
      end
      if (arm_i && !busy_q) begin
        busy_q = 1'b1;
        kind_q = kind_i;
        exp_q  = exp_i;
        row_q  = row_i;
        age    = 0;
      end else if (busy_q) begin
        age++;
      end
      // read data belongs to the request of the previous cycle only
      if (csr_rvalid_i) begin
        if (busy_q && kind_q == CSR_RD && age == 1) begin
          report("csr_rdata_o", csr_rdata_i);
          busy_q = 1'b0;
        end else begin
          fail_words("csr_rvalid_o came without a register read one cycle before");
        end
      end
      if (hmem_rvalid_i) begin
        if (busy_q && kind_q == MEM_RD && age == 1) begin
          report("hmem_rdata_o", hmem_rdata_i);
          busy_q = 1'b0;
        end else begin
          fail_words("hmem_rvalid_o came without a granted read one cycle before");
        end
      end
      if (busy_q && kind_q != WAIT_DONE && age >= 1) begin
        fail_words("no read valid one cycle after the request");
        busy_q = 1'b0;
      end
      if (busy_q && kind_q == WAIT_DONE && done_i) begin
        report("done_o count", 64'(done_cnt));
        busy_q = 1'b0;
      end
    end
  end

endmodule

/* tb_dot_accel.sv */
/*
  testbench top for the dot-product accelerator
  - clock, reset, input drive 10 ns after the rising edge
  - LFSR vector data and stimulus table, applied in a loop
  - cycle limit and closing summary
*/

`timescale 1ns/1ps

module tb_dot_accel;

  localparam int CSR_WR         = 0;
  localparam int CSR_RD         = 1;
  localparam int MEM_WR         = 2;
  localparam int MEM_RD         = 3;
  localparam int WAIT_DONE      = 4;
  localparam int RESET_CYCLES   = 5;
  localparam int CYCLES_PER_ROW = 60;
  localparam int A_BASE         = 'h10;
  localparam int B_BASE         = 'h20;
  localparam int RES_BASE       = 'h40;

  logic                       clk_i = 1'b0;
  logic                       reset_i;
  logic                       csr_we_i;
  logic                       csr_re_i;
  logic [2:0]                 csr_addr_i;
  logic [63:0]                csr_wdata_i;
  logic [63:0]                csr_rdata_o;
  logic                       csr_rvalid_o;
  logic                       hmem_req_i;
  logic                       hmem_we_i;
  logic [mem_pkg::ADDR_W-1:0] hmem_addr_i;
  logic [63:0]                hmem_wdata_i;
  logic                       hmem_gnt_o;
  logic                       hmem_rvalid_o;
  logic [63:0]                hmem_rdata_o;
  logic                       done_o;

  logic        chk_arm;
  int          chk_kind;
  logic [63:0] chk_exp;
  int          chk_row;
  logic        chk_busy;
  int          pass_cnt;
  int          fail_cnt;

  // stimulus table with one entry per row in each queue
  int          row_kind [$];
  int          row_addr [$];
  logic [63:0] row_data [$];
  logic [63:0] row_exp [$];

  logic [15:0] lfsr_q;
  logic [63:0] vec_a [8];
  logic [63:0] vec_b [8];
  int          cycle_cnt = 0;
  int          cycle_limit = 0;

  dot_accel_top uut (.*);

  tb_checker u_check (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .arm_i         (chk_arm),
    .kind_i        (chk_kind),
    .exp_i         (chk_exp),
    .row_i         (chk_row),
    .csr_rdata_i   (csr_rdata_o),
    .csr_rvalid_i  (csr_rvalid_o),
    .hmem_rdata_i  (hmem_rdata_o),
    .hmem_rvalid_i (hmem_rvalid_o),
    .done_i        (done_o),
    .busy_o        (chk_busy),
    .pass_cnt_o    (pass_cnt),
    .fail_cnt_o    (fail_cnt)
  );

  always #50 clk_i = ~clk_i;

  // 16-bit Fibonacci LFSR with taps 16 14 13 11
  function automatic logic [15:0] lfsr_next(logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  function automatic logic [63:0] random_word();
    logic [63:0] w;
    w = '0;
    for (int i = 0; i < 64; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      w = {w[62:0], lfsr_q[0]};
    end
    return w;
  endfunction

  // sum of a[i]*b[i] mod 2^64 over the first len elements
  function automatic logic [63:0] dot_product(int len);
    logic [63:0] acc;
    acc = '0;
    for (int i = 0; i < len && i < 8; i++) begin
      acc = acc + vec_a[i] * vec_b[i];
    end
    return acc;
  endfunction

  function automatic void add_row(int kind, int addr, logic [63:0] data, logic [63:0] exp);
    row_kind.push_back(kind);
    row_addr.push_back(addr);
    row_data.push_back(data);
    row_exp.push_back(exp);
  endfunction

  function automatic void add_start(int res_addr, int len);
    add_row(CSR_WR, dot_pkg::RES_PTR, 64'(res_addr), '0);
    add_row(CSR_WR, dot_pkg::LEN, 64'(len), '0);
    add_row(CSR_WR, dot_pkg::START, 64'd1, '0);
  endfunction

  task automatic build_table();
    logic [63:0] dot8;
    logic [63:0] dot3;
    for (int i = 0; i < 8; i++) begin
      vec_a[i] = random_word();
      vec_b[i] = random_word();
    end
    dot8 = dot_product(8);
    dot3 = dot_product(3);
    // register readback where LEN clips at 8
    add_row(CSR_RD, dot_pkg::STATUS, '0, '0);
    add_row(CSR_WR, dot_pkg::A_PTR, 64'(A_BASE), '0);
    add_row(CSR_RD, dot_pkg::A_PTR, '0, 64'(A_BASE));
    add_row(CSR_WR, dot_pkg::B_PTR, 64'(B_BASE), '0);
    add_row(CSR_RD, dot_pkg::B_PTR, '0, 64'(B_BASE));
    add_row(CSR_WR, dot_pkg::RES_PTR, 64'(RES_BASE), '0);
    add_row(CSR_RD, dot_pkg::RES_PTR, '0, 64'(RES_BASE));
    add_row(CSR_WR, dot_pkg::LEN, 64'd13, '0);
    add_row(CSR_RD, dot_pkg::LEN, '0, 64'd8);
    add_row(CSR_WR, dot_pkg::LEN, 64'd5, '0);
    add_row(CSR_RD, dot_pkg::LEN, '0, 64'd5);
    // vectors in through the host port and back out
    for (int i = 0; i < 8; i++) begin
      add_row(MEM_WR, A_BASE + i, vec_a[i], '0);
      add_row(MEM_WR, B_BASE + i, vec_b[i], '0);
    end
    for (int i = 0; i < 8; i++) begin
      add_row(MEM_RD, A_BASE + i, '0, vec_a[i]);
      add_row(MEM_RD, B_BASE + i, '0, vec_b[i]);
    end
    // result words start with a marker taken from their address
    for (int i = 0; i < 5; i++) begin
      add_row(MEM_WR, RES_BASE + i, ~64'(RES_BASE + i), '0);
    end
    // full length job
    add_start(RES_BASE, 8);
    add_row(WAIT_DONE, 0, '0, 64'd1);
    add_row(MEM_RD, RES_BASE, '0, dot8);
    add_row(CSR_RD, dot_pkg::RESULT, '0, dot8);
    add_row(CSR_RD, dot_pkg::STATUS, '0, 64'd2);
    // short and empty vectors with tail elements left in memory
    add_start(RES_BASE + 1, 3);
    add_row(WAIT_DONE, 0, '0, 64'd2);
    add_row(MEM_RD, RES_BASE + 1, '0, dot3);
    add_row(CSR_RD, dot_pkg::RESULT, '0, dot3);
    add_start(RES_BASE + 2, 0);
    add_row(WAIT_DONE, 0, '0, 64'd3);
    add_row(MEM_RD, RES_BASE + 2, '0, '0);
    add_row(CSR_RD, dot_pkg::RESULT, '0, '0);
    // host writes and reads keep the engine waiting during a job
    add_start(RES_BASE + 3, 8);
    for (int i = 0; i < 8; i++) begin
      add_row(MEM_WR, A_BASE + i, vec_a[i], '0);
      add_row(MEM_RD, A_BASE + i, '0, vec_a[i]);
    end
    add_row(WAIT_DONE, 0, '0, 64'd4);
    add_row(MEM_RD, RES_BASE + 3, '0, dot8);
    add_row(CSR_RD, dot_pkg::RESULT, '0, dot8);
    // second START while busy must not start a job
    add_start(RES_BASE + 4, 8);
    add_row(CSR_WR, dot_pkg::START, 64'd1, '0);
    add_row(WAIT_DONE, 0, '0, 64'd5);
    add_row(CSR_RD, dot_pkg::RESULT, '0, dot8);
    add_row(MEM_RD, RES_BASE + 4, '0, dot8);
    add_row(CSR_RD, dot_pkg::STATUS, '0, 64'd2);
    // an extra done from the ignored START would shift this count
    add_start(RES_BASE + 5, 0);
    add_row(WAIT_DONE, 0, '0, 64'd6);
  endtask

  task automatic wait_checker();
    while (chk_busy) begin
      @(posedge clk_i);
      #10;
    end
  endtask

  task automatic wait_grant();
    @(negedge clk_i);
    while (!hmem_gnt_o) begin
      @(negedge clk_i);
    end
    @(posedge clk_i);
    #10;
  endtask

  task automatic apply_row(int r);
    chk_row  = r;
    chk_kind = row_kind[r];
    chk_exp  = row_exp[r];
    case (row_kind[r])
      CSR_WR: begin
        csr_we_i    = 1'b1;
        csr_addr_i  = row_addr[r][2:0];
        csr_wdata_i = row_data[r];
        @(posedge clk_i);
        #10;
        csr_we_i = 1'b0;
      end
      CSR_RD: begin
        csr_re_i   = 1'b1;
        csr_addr_i = row_addr[r][2:0];
        chk_arm    = 1'b1;
        @(posedge clk_i);
        #10;
        csr_re_i = 1'b0;
        chk_arm  = 1'b0;
        wait_checker();
      end
      MEM_WR, MEM_RD: begin
        hmem_req_i   = 1'b1;
        hmem_we_i    = (row_kind[r] == MEM_WR);
        hmem_addr_i  = row_addr[r][mem_pkg::ADDR_W-1:0];
        hmem_wdata_i = row_data[r];
        chk_arm      = (row_kind[r] == MEM_RD);
        wait_grant();
        hmem_req_i = 1'b0;
        chk_arm    = 1'b0;
        wait_checker();
      end
      default: begin
        chk_arm = 1'b1;
        @(posedge clk_i);
        #10;
        chk_arm = 1'b0;
        wait_checker();
      end
    endcase
  endtask

  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("timeout waiting for done_o or read data after %0d cycles (row %0d)",
               cycle_cnt, chk_row);
      $display("Some tests failed");
      $finish;
    end
  end

  initial begin
    reset_i      = 1'b1;
    csr_we_i     = 1'b0;
    csr_re_i     = 1'b0;
    csr_addr_i   = '0;
    csr_wdata_i  = '0;
    hmem_req_i   = 1'b0;
    hmem_we_i    = 1'b0;
    hmem_addr_i  = '0;
    hmem_wdata_i = '0;
    chk_arm      = 1'b0;
    chk_kind     = 0;
    chk_exp      = '0;
    chk_row      = 0;
    lfsr_q       = 16'(88519);
    build_table();
    cycle_limit = row_kind.size() * CYCLES_PER_ROW + RESET_CYCLES;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #10;
    reset_i = 1'b0;
    for (int r = 0; r < row_kind.size(); r++) begin
      apply_row(r);
    end
    // room for a stray pulse to show up
    repeat (4) @(posedge clk_i);
    $display("rows %0d, checks passed %0d, checks failed %0d",
             row_kind.size(), pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

/* vlog.f */
mem_pkg.sv
dot_pkg.sv
mem_bus_if.sv
dot_csr.sv
dot_engine.sv
mem_arbiter.sv
scratch_mem.sv
dot_accel_top.sv
tb_checker.sv
tb_dot_accel.sv
